// ==== aes_round_ctrl.f ====
source/aes_ctrl_pkg.sv
source/aes_ctrl_rail_if.sv
source/aes_ctrl_rail_fsm.sv
source/aes_ctrl_rail_merge.sv
source/aes_round_ctrl.sv
sim/aes_round_ctrl_assert.sv
sim/tb_aes_round_ctrl.sv

// ==== sim/tb_aes_round_ctrl.sv ====
`timescale 1ns/1ns

module tb_aes_round_ctrl;

  localparam bit          FwdOnly   = 1'b0;
  localparam int          NumJobs   = 40;
  localparam int unsigned TimeoutNs = NumJobs * (16 + 6) * 4 + 4000;   // Jobs plus margin

  logic                                 clk_i = 1'b0;
  logic                                 rst_ni;
  aes_ctrl_pkg::sp2v_e                  in_valid, out_ready, dec_key_gen;
  aes_ctrl_pkg::ciph_op_e               op;
  aes_ctrl_pkg::key_len_e               key_len;
  logic                                 alert_fatal;
  aes_ctrl_pkg::sp2v_e                  in_ready, out_valid, state_we, key_expand_en;
  aes_ctrl_pkg::state_sel_e             state_sel;
  aes_ctrl_pkg::add_rk_sel_e            add_rk_sel;
  aes_ctrl_pkg::ciph_op_e               key_expand_op;
  logic [aes_ctrl_pkg::RndCtrWidth-1:0] key_expand_round;
  logic                                 alert;
  logic [31:0]                          lcg_state = 32'hd7f79590;

  always #2 clk_i = ~clk_i;

  aes_round_ctrl #(.CiphOpFwdOnly(FwdOnly)) dut (
    .clk_i (clk_i), .rst_ni (rst_ni), .in_valid_i (in_valid), .in_ready_o (in_ready),
    .op_i (op), .key_len_i (key_len), .dec_key_gen_i (dec_key_gen),
    .out_valid_o (out_valid), .out_ready_i (out_ready), .state_sel_o (state_sel),
    .state_we_o (state_we), .add_rk_sel_o (add_rk_sel), .key_expand_en_o (key_expand_en),
    .key_expand_op_o (key_expand_op), .key_expand_round_o (key_expand_round),
    .alert_fatal_i (alert_fatal), .alert_o (alert)
  );

  //////////////////////////////////////////////////
  // Model and helpers
  //////////////////////////////////////////////////

  function automatic int unsigned next_rand(input int unsigned range);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return (lcg_state >> 8) % range;   // Low bits of an LCG are weak
  endfunction

  // Nr per key length
  function automatic int expected_rounds(input aes_ctrl_pkg::key_len_e kl);
    case (kl)
      aes_ctrl_pkg::AES_192: return 12;
      aes_ctrl_pkg::AES_256: return 14;
      default:               return 10;
    endcase
  endfunction

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("TB FAILED");
      $fatal(1, "Stopped at first error");
    end
  endtask

  task automatic set_idle_inputs();
    in_valid    = aes_ctrl_pkg::SP2V_LOW;
    out_ready   = aes_ctrl_pkg::SP2V_LOW;
    dec_key_gen = aes_ctrl_pkg::SP2V_LOW;
    op          = aes_ctrl_pkg::CIPH_FWD;
    key_len     = aes_ctrl_pkg::AES_128;
    alert_fatal = 1'b0;
  endtask

  task automatic check_idle();
    check(in_ready, aes_ctrl_pkg::SP2V_HIGH, "in_ready when idle");
    check(out_valid, aes_ctrl_pkg::SP2V_LOW, "out_valid when idle");
    check(state_we, aes_ctrl_pkg::SP2V_LOW, "state_we when idle");
    check(key_expand_en, aes_ctrl_pkg::SP2V_LOW, "key_expand_en when idle");
    check(state_sel, aes_ctrl_pkg::STATE_ROUND, "state_sel when idle");
    check(add_rk_sel, aes_ctrl_pkg::ADD_RK_ROUND, "add_rk_sel when idle");
    check(key_expand_round, 0, "round counter when idle");
    check(alert, 1'b0, "alert when idle");
  endtask

  task automatic apply_reset();
    set_idle_inputs();
    rst_ni = 1'b0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_idle();
  endtask

  // Error state holds with legal inputs applied again
  task automatic check_error_hold(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      set_idle_inputs();
      check(alert, 1'b1, "alert after error");
      check(in_ready, aes_ctrl_pkg::SP2V_LOW, "in_ready after error");
      check(out_valid, aes_ctrl_pkg::SP2V_LOW, "out_valid after error");
      check(state_we, aes_ctrl_pkg::SP2V_LOW, "state_we after error");
      check(key_expand_en, aes_ctrl_pkg::SP2V_LOW, "key_expand_en after error");
    end
  endtask

  task automatic run_job(input aes_ctrl_pkg::key_len_e kl, input aes_ctrl_pkg::ciph_op_e o,
                         input logic kg, input int stall);
    int                        nr;
    aes_ctrl_pkg::ciph_op_e    exp_op;
    aes_ctrl_pkg::sp2v_e       exp_we;
    aes_ctrl_pkg::add_rk_sel_e exp_rk;
    nr     = expected_rounds(kl);
    exp_op = (kg || FwdOnly) ? aes_ctrl_pkg::CIPH_FWD : o;
    exp_we = kg ? aes_ctrl_pkg::SP2V_LOW : aes_ctrl_pkg::SP2V_HIGH;
    check_idle();
    in_valid    = aes_ctrl_pkg::SP2V_HIGH;
    key_len     = kl;
    op          = o;
    dec_key_gen = kg ? aes_ctrl_pkg::SP2V_HIGH : aes_ctrl_pkg::SP2V_LOW;
    for (int c = 0; c <= nr; c++) begin
      @(negedge clk_i);
      in_valid  = aes_ctrl_pkg::SP2V_LOW;
      op        = aes_ctrl_pkg::ciph_op_e'(next_rand(2));   // Must not disturb captured op
      out_ready = next_rand(2) ? aes_ctrl_pkg::SP2V_HIGH : aes_ctrl_pkg::SP2V_LOW;
      exp_rk    = (c == 0) ? aes_ctrl_pkg::ADD_RK_INIT :
                  (c == nr) ? aes_ctrl_pkg::ADD_RK_FINAL : aes_ctrl_pkg::ADD_RK_ROUND;
      check(in_ready, aes_ctrl_pkg::SP2V_LOW, "in_ready while busy");
      check(out_valid, aes_ctrl_pkg::SP2V_LOW, "out_valid before Nr+1 cycles");
      check(key_expand_round, c, "round counter");
      check(state_sel, (c == 0) ? aes_ctrl_pkg::STATE_INIT : aes_ctrl_pkg::STATE_ROUND,
            "state_sel");
      check(add_rk_sel, exp_rk, "add_rk_sel");
      check(state_we, exp_we, "state_we");
      check(key_expand_en, aes_ctrl_pkg::SP2V_HIGH, "key_expand_en");
      check(key_expand_op, exp_op, "key_expand_op");
      check(alert, 1'b0, "alert during job");
    end
    // DONE, held under back-pressure
    for (int k = 0; k <= stall; k++) begin
      @(negedge clk_i);
      check(out_valid, aes_ctrl_pkg::SP2V_HIGH, "out_valid in DONE");
      check(in_ready, aes_ctrl_pkg::SP2V_LOW, "in_ready in DONE");
      check(state_we, aes_ctrl_pkg::SP2V_LOW, "state_we in DONE");
      check(key_expand_en, aes_ctrl_pkg::SP2V_LOW, "key_expand_en in DONE");
      check(key_expand_round, nr, "round counter in DONE");
      check(key_expand_op, exp_op, "key_expand_op in DONE");
      out_ready = (k == stall) ? aes_ctrl_pkg::SP2V_HIGH : aes_ctrl_pkg::SP2V_LOW;
      in_valid  = next_rand(2) ? aes_ctrl_pkg::SP2V_HIGH : aes_ctrl_pkg::SP2V_LOW;
    end
    @(negedge clk_i);
    in_valid  = aes_ctrl_pkg::SP2V_LOW;
    out_ready = aes_ctrl_pkg::SP2V_LOW;
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin : stimulus
    aes_ctrl_pkg::key_len_e kl;
    aes_ctrl_pkg::ciph_op_e o;
    logic                   kg;
    apply_reset();
    for (int j = 0; j < NumJobs; j++) begin
      if (j < 6) begin   // Sweep key lengths and ops first
        kl = aes_ctrl_pkg::key_len_e'(3'b001 << (j % 3));
        o  = aes_ctrl_pkg::ciph_op_e'(j / 3);
        kg = 1'b0;
      end else begin
        kl = aes_ctrl_pkg::key_len_e'(3'b001 << next_rand(3));
        o  = aes_ctrl_pkg::ciph_op_e'(next_rand(2));
        kg = (j == 6) || (next_rand(3) == 0);
      end
      repeat (next_rand(6)) begin
        check_idle();
        @(negedge clk_i);
      end
      run_job(kl, o, kg, next_rand(6));
    end

    // Invalid sparse code on in_valid
    in_valid = aes_ctrl_pkg::sp2v_e'(next_rand(2) ? 2'b11 : 2'b00);
    check_error_hold(8);
    apply_reset();
    run_job(aes_ctrl_pkg::AES_128, aes_ctrl_pkg::CIPH_FWD, 1'b0, 1);

    // Fatal alert in the middle of a job
    in_valid = aes_ctrl_pkg::SP2V_HIGH;
    key_len  = aes_ctrl_pkg::AES_256;
    op       = aes_ctrl_pkg::CIPH_INV;
    @(negedge clk_i);
    in_valid = aes_ctrl_pkg::SP2V_LOW;
    repeat (5) @(negedge clk_i);
    alert_fatal = 1'b1;
    check_error_hold(8);
    apply_reset();
    run_job(aes_ctrl_pkg::AES_192, aes_ctrl_pkg::CIPH_INV, 1'b0, 0);

    // Valid job with a key length that is not one-hot
    in_valid = aes_ctrl_pkg::SP2V_HIGH;
    key_len  = aes_ctrl_pkg::key_len_e'(3'b011);
    check_error_hold(8);
    apply_reset();
    run_job(aes_ctrl_pkg::AES_256, aes_ctrl_pkg::CIPH_INV, 1'b1, 2);

    $display("TB PASSED");
    $finish;
  end

  // Bound assertions
  always @(dut.u_assert.fail_count) begin
    if (dut.u_assert.fail_count != 0) begin
      $display("Concurrent assertion failed at %0t ns", $time);
      $display("TB FAILED");
      $fatal(1, "Stopped at first error");
    end
  end

  initial begin : watchdog
    #(TimeoutNs);
    $display("Simulation timed out after %0d ns", TimeoutNs);
    $display("TB FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule

// ==== sim/aes_round_ctrl_assert.sv ====
`timescale 1ns/1ns

module aes_round_ctrl_assert (
  input logic                                 clk_i,
  input logic                                 rst_ni,
  input aes_ctrl_pkg::sp2v_e                  in_ready_i,
  input aes_ctrl_pkg::sp2v_e                  out_valid_i,
  input logic [aes_ctrl_pkg::RndCtrWidth-1:0] round_i,
  input logic                                 alert_i
);

  int fail_count = 0;   // Number of failed properties

  // Error state is terminal until reset
  alert_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni) alert_i |=> alert_i)
    else begin
      fail_count++;
      $error("alert_o dropped without a reset");
    end

  busy_or_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(out_valid_i == aes_ctrl_pkg::SP2V_HIGH && in_ready_i == aes_ctrl_pkg::SP2V_HIGH))
    else begin
      fail_count++;
      $error("out_valid_o and in_ready_o both high");
    end

  out_valid_enc: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !alert_i |-> out_valid_i inside {aes_ctrl_pkg::SP2V_HIGH, aes_ctrl_pkg::SP2V_LOW})
    else begin
      fail_count++;
      $error("out_valid_o has an invalid sparse code");
    end

  round_range: assert property (@(posedge clk_i) disable iff (!rst_ni) round_i <= 4'd14)
    else begin
      fail_count++;
      $error("key_expand_round_o above 14");
    end

endmodule

bind aes_round_ctrl aes_round_ctrl_assert u_assert (
  .clk_i       ( clk_i              ),
  .rst_ni      ( rst_ni             ),
  .in_ready_i  ( in_ready_o         ),
  .out_valid_i ( out_valid_o        ),
  .round_i     ( key_expand_round_o ),
  .alert_i     ( alert_o            )
);

// ==== source/aes_round_ctrl.sv ====
`timescale 1ns/1ns

module aes_round_ctrl #(
  parameter bit CiphOpFwdOnly = 1'b0
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,

  // Job request
  input  aes_ctrl_pkg::sp2v_e                  in_valid_i,
  output aes_ctrl_pkg::sp2v_e                  in_ready_o,
  input  aes_ctrl_pkg::ciph_op_e               op_i,
  input  aes_ctrl_pkg::key_len_e               key_len_i,
  input  aes_ctrl_pkg::sp2v_e                  dec_key_gen_i,

  // Result
  output aes_ctrl_pkg::sp2v_e                  out_valid_o,
  input  aes_ctrl_pkg::sp2v_e                  out_ready_i,

  // Data path and key expand control
  output aes_ctrl_pkg::state_sel_e             state_sel_o,
  output aes_ctrl_pkg::sp2v_e                  state_we_o,
  output aes_ctrl_pkg::add_rk_sel_e            add_rk_sel_o,
  output aes_ctrl_pkg::sp2v_e                  key_expand_en_o,
  output aes_ctrl_pkg::ciph_op_e               key_expand_op_o,
  output logic [aes_ctrl_pkg::RndCtrWidth-1:0] key_expand_round_o,

  input  logic                                 alert_fatal_i,
  output logic                                 alert_o
);

  aes_ctrl_pkg::sp2v_u in_valid_u, out_ready_u, dec_key_gen_u;
  logic                err;

  // Split sparse inputs into rail bits
  assign in_valid_u    = aes_ctrl_pkg::sp2v_u'(in_valid_i);
  assign out_ready_u   = aes_ctrl_pkg::sp2v_u'(out_ready_i);
  assign dec_key_gen_u = aes_ctrl_pkg::sp2v_u'(dec_key_gen_i);

  aes_ctrl_rail_if rail_p_if ();
  aes_ctrl_rail_if rail_n_if ();

  aes_ctrl_rail_fsm #(
    .RailActiveHigh ( 1'b1          ),
    .CiphOpFwdOnly  ( CiphOpFwdOnly )
  ) u_rail_p (
    .clk_i         ( clk_i                        ),
    .rst_ni        ( rst_ni                       ),
    .in_valid_i    ( in_valid_u.rails.rail_p      ),
    .out_ready_i   ( out_ready_u.rails.rail_p     ),
    .dec_key_gen_i ( dec_key_gen_u.rails.rail_p   ),
    .op_i          ( op_i                         ),
    .key_len_i     ( key_len_i                    ),
    .err_i         ( err                          ),
    .rail_o        ( rail_p_if.rail               )
  );

  // Active-low rail
  aes_ctrl_rail_fsm #(
    .RailActiveHigh ( 1'b0          ),
    .CiphOpFwdOnly  ( CiphOpFwdOnly )
  ) u_rail_n (
    .clk_i         ( clk_i                        ),
    .rst_ni        ( rst_ni                       ),
    .in_valid_i    ( in_valid_u.rails.rail_n      ),
    .out_ready_i   ( out_ready_u.rails.rail_n     ),
    .dec_key_gen_i ( dec_key_gen_u.rails.rail_n   ),
    .op_i          ( op_i                         ),
    .key_len_i     ( key_len_i                    ),
    .err_i         ( err                          ),
    .rail_o        ( rail_n_if.rail               )
  );

  aes_ctrl_rail_merge u_merge (
    .rail_p_i           ( rail_p_if.merge    ),
    .rail_n_i           ( rail_n_if.merge    ),
    .in_valid_i         ( in_valid_i         ),
    .out_ready_i        ( out_ready_i        ),
    .dec_key_gen_i      ( dec_key_gen_i      ),
    .key_len_i          ( key_len_i          ),
    .alert_fatal_i      ( alert_fatal_i      ),
    .err_o              ( err                ),   // Back to both rails
    .in_ready_o         ( in_ready_o         ),
    .out_valid_o        ( out_valid_o        ),
    .state_we_o         ( state_we_o         ),
    .key_expand_en_o    ( key_expand_en_o    ),
    .state_sel_o        ( state_sel_o        ),
    .add_rk_sel_o       ( add_rk_sel_o       ),
    .key_expand_op_o    ( key_expand_op_o    ),
    .key_expand_round_o ( key_expand_round_o ),
    .alert_o            ( alert_o            )
  );

endmodule

// ==== source/aes_ctrl_rail_merge.sv ====
`timescale 1ns/1ns

module aes_ctrl_rail_merge (
  aes_ctrl_rail_if.merge                      rail_p_i,
  aes_ctrl_rail_if.merge                      rail_n_i,

  // Full sparse inputs for encoding checks
  input  aes_ctrl_pkg::sp2v_e                 in_valid_i,
  input  aes_ctrl_pkg::sp2v_e                 out_ready_i,
  input  aes_ctrl_pkg::sp2v_e                 dec_key_gen_i,
  input  aes_ctrl_pkg::key_len_e              key_len_i,
  input  logic                                alert_fatal_i,

  output logic                                err_o,

  output aes_ctrl_pkg::sp2v_e                 in_ready_o,
  output aes_ctrl_pkg::sp2v_e                 out_valid_o,
  output aes_ctrl_pkg::sp2v_e                 state_we_o,
  output aes_ctrl_pkg::sp2v_e                 key_expand_en_o,
  output aes_ctrl_pkg::state_sel_e            state_sel_o,
  output aes_ctrl_pkg::add_rk_sel_e           add_rk_sel_o,
  output aes_ctrl_pkg::ciph_op_e              key_expand_op_o,
  output logic [aes_ctrl_pkg::RndCtrWidth-1:0] key_expand_round_o,
  output logic                                alert_o
);

  localparam int unsigned NumSpIn = 3;

  aes_ctrl_pkg::sp2v_u [NumSpIn-1:0] sp_in;
  logic [NumSpIn-1:0]                sp_in_err;
  aes_ctrl_pkg::sp2v_u               in_ready_u, out_valid_u, state_we_u, key_expand_en_u;
  logic                              sp_enc_err;
  logic                              key_len_err;
  logic                              rail_err;

  //////////////////////////////////////////////////
  // Sparse outputs
  //////////////////////////////////////////////////

  // Each rail owns one bit of every sparse output
  always_comb begin : rebuild_sparse
    in_ready_u.rails.rail_p      = rail_p_i.in_ready;
    in_ready_u.rails.rail_n      = rail_n_i.in_ready;
    out_valid_u.rails.rail_p     = rail_p_i.out_valid;
    out_valid_u.rails.rail_n     = rail_n_i.out_valid;
    state_we_u.rails.rail_p      = rail_p_i.state_we;
    state_we_u.rails.rail_n      = rail_n_i.state_we;
    key_expand_en_u.rails.rail_p = rail_p_i.key_expand_en;
    key_expand_en_u.rails.rail_n = rail_n_i.key_expand_en;
  end

  assign in_ready_o      = in_ready_u.code;
  assign out_valid_o     = out_valid_u.code;
  assign state_we_o      = state_we_u.code;
  assign key_expand_en_o = key_expand_en_u.code;

  //////////////////////////////////////////////////
  // Plain outputs
  //////////////////////////////////////////////////

  // OR of both rails, a mismatch is caught below
  assign state_sel_o  = aes_ctrl_pkg::state_sel_e'(rail_p_i.state_sel | rail_n_i.state_sel);
  assign add_rk_sel_o = aes_ctrl_pkg::add_rk_sel_e'(rail_p_i.add_rk_sel | rail_n_i.add_rk_sel);
  assign key_expand_op_o =
      aes_ctrl_pkg::ciph_op_e'(rail_p_i.key_expand_op | rail_n_i.key_expand_op);
  assign key_expand_round_o = rail_p_i.rnd_ctr | rail_n_i.rnd_ctr;
  assign alert_o            = rail_p_i.alert | rail_n_i.alert;

  //////////////////////////////////////////////////
  // Error detection
  //////////////////////////////////////////////////

  assign sp_in[0] = aes_ctrl_pkg::sp2v_u'(in_valid_i);
  assign sp_in[1] = aes_ctrl_pkg::sp2v_u'(out_ready_i);
  assign sp_in[2] = aes_ctrl_pkg::sp2v_u'(dec_key_gen_i);

  // Valid codes always have the two rail bits different
  always_comb begin : sparse_check
    for (int i = 0; i < NumSpIn; i++) begin
      sp_in_err[i] = sp_in[i].rails.rail_p == sp_in[i].rails.rail_n;
    end
  end

  assign sp_enc_err  = |sp_in_err;
  assign key_len_err = (in_valid_i == aes_ctrl_pkg::SP2V_HIGH) &&
                       !aes_ctrl_pkg::key_len_valid(key_len_i);

  // Rails must agree on every shared value
  assign rail_err = (rail_p_i.state_sel     != rail_n_i.state_sel)  ||
                    (rail_p_i.add_rk_sel    != rail_n_i.add_rk_sel) ||
                    (rail_p_i.rnd_ctr       != rail_n_i.rnd_ctr)    ||
                    (rail_p_i.key_expand_op != rail_n_i.key_expand_op);

  assign err_o = sp_enc_err | key_len_err | rail_err | alert_fatal_i;

endmodule

// ==== source/aes_ctrl_rail_fsm.sv ====
`timescale 1ns/1ns

module aes_ctrl_rail_fsm #(
  parameter bit RailActiveHigh = 1'b1,
  parameter bit CiphOpFwdOnly  = 1'b0
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Single rail bits of the sparse inputs
  input  logic                   in_valid_i,
  input  logic                   out_ready_i,
  input  logic                   dec_key_gen_i,

  input  aes_ctrl_pkg::ciph_op_e op_i,
  input  aes_ctrl_pkg::key_len_e key_len_i,
  input  logic                   err_i,

  aes_ctrl_rail_if.rail          rail_o
);

  localparam int unsigned CtrW = aes_ctrl_pkg::RndCtrWidth;
  localparam logic        Inv  = ~RailActiveHigh;   // Flip bits on the active-low rail

  localparam logic [2:0] StIdle  = 3'b000;
  localparam logic [2:0] StInit  = 3'b001;
  localparam logic [2:0] StRound = 3'b011;
  localparam logic [2:0] StFinal = 3'b010;
  localparam logic [2:0] StDone  = 3'b110;
  localparam logic [2:0] StError = 3'b101;

  logic [2:0]             state_d, state_q;
  logic [CtrW-1:0]        rnd_ctr_d, rnd_ctr_q;
  logic [CtrW-1:0]        nr_q;
  logic                   dec_key_gen_q;
  aes_ctrl_pkg::ciph_op_e key_expand_op_q;
  logic                   capture;

  // Inputs and outputs in active-high sense
  logic                   in_valid, out_ready, dec_key_gen;
  logic                   in_ready, out_valid, state_we, key_expand_en;
  aes_ctrl_pkg::state_sel_e  state_sel;
  aes_ctrl_pkg::add_rk_sel_e add_rk_sel;
  logic                   alert;

  assign in_valid    = in_valid_i ^ Inv;
  assign out_ready   = out_ready_i ^ Inv;
  assign dec_key_gen = dec_key_gen_i ^ Inv;

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin : next_state
    state_d   = state_q;
    rnd_ctr_d = rnd_ctr_q;
    capture   = 1'b0;

    case (state_q)
      StIdle: begin
        if (in_valid) begin   // Acceptance edge
          capture   = 1'b1;
          state_d   = StInit;
          rnd_ctr_d = '0;
        end
      end
      StInit: begin
        state_d   = StRound;
        rnd_ctr_d = CtrW'(1);
      end
      StRound: begin
        // Last middle round is Nr-1
        if (rnd_ctr_q == nr_q - CtrW'(1)) begin
          state_d = StFinal;
        end
        rnd_ctr_d = rnd_ctr_q + CtrW'(1);
      end
      StFinal: begin
        state_d = StDone;
      end
      StDone: begin
        if (out_ready) begin
          state_d   = StIdle;
          rnd_ctr_d = '0;
        end
      end
      StError: begin
        state_d = StError;  // Terminal until reset
      end
      default: begin
        state_d = StError;
      end
    endcase

    // Any detected fault wins over normal progress
    if (err_i) begin
      state_d   = StError;
      rnd_ctr_d = '0;
    end
  end

  //////////////////////////////////////////////////
  // Output decode
  //////////////////////////////////////////////////

  always_comb begin : out_decode
    in_ready      = 1'b0;
    out_valid     = 1'b0;
    state_we      = 1'b0;
    key_expand_en = 1'b0;
    state_sel     = aes_ctrl_pkg::STATE_ROUND;
    add_rk_sel    = aes_ctrl_pkg::ADD_RK_ROUND;
    alert         = 1'b0;

    case (state_q)
      StIdle: in_ready = 1'b1;
      StInit: begin
        state_sel     = aes_ctrl_pkg::STATE_INIT;
        add_rk_sel    = aes_ctrl_pkg::ADD_RK_INIT;
        state_we      = ~dec_key_gen_q;   // Key generation leaves the state alone
        key_expand_en = 1'b1;
      end
      StRound: begin
        state_we      = ~dec_key_gen_q;
        key_expand_en = 1'b1;
      end
      StFinal: begin
        add_rk_sel    = aes_ctrl_pkg::ADD_RK_FINAL;
        state_we      = ~dec_key_gen_q;
        key_expand_en = 1'b1;
      end
      StDone:  out_valid = 1'b1;
      default: alert = 1'b1;   // Error state and unused codes
    endcase
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q         <= StIdle;
      rnd_ctr_q       <= '0;
      nr_q            <= '0;
      dec_key_gen_q   <= 1'b0;
      key_expand_op_q <= aes_ctrl_pkg::CIPH_FWD;
    end else begin
      state_q   <= state_d;
      rnd_ctr_q <= rnd_ctr_d;
      if (capture) begin   // Job parameters
        nr_q            <= aes_ctrl_pkg::num_rounds(key_len_i);
        dec_key_gen_q   <= dec_key_gen;
        key_expand_op_q <= (dec_key_gen || CiphOpFwdOnly) ? aes_ctrl_pkg::CIPH_FWD : op_i;
      end
    end
  end

  assign rail_o.in_ready      = in_ready ^ Inv;
  assign rail_o.out_valid     = out_valid ^ Inv;
  assign rail_o.state_we      = state_we ^ Inv;
  assign rail_o.key_expand_en = key_expand_en ^ Inv;
  assign rail_o.state_sel     = state_sel;
  assign rail_o.add_rk_sel    = add_rk_sel;
  assign rail_o.rnd_ctr       = rnd_ctr_q;
  assign rail_o.key_expand_op = key_expand_op_q;
  assign rail_o.alert         = alert;

endmodule

// ==== source/aes_ctrl_rail_if.sv ====
`timescale 1ns/1ns

interface aes_ctrl_rail_if;

  // Sparse bits, each in the rail's own polarity
  logic                                   in_ready;
  logic                                   out_valid;
  logic                                   state_we;
  logic                                   key_expand_en;

  // Plain values, same on both rails when healthy
  aes_ctrl_pkg::state_sel_e               state_sel;
  aes_ctrl_pkg::add_rk_sel_e              add_rk_sel;
  logic [aes_ctrl_pkg::RndCtrWidth-1:0]   rnd_ctr;
  aes_ctrl_pkg::ciph_op_e                 key_expand_op;
  logic                                   alert;      // Always active high

  modport rail (
    output in_ready,
    output out_valid,
    output state_we,
    output key_expand_en,
    output state_sel,
    output add_rk_sel,
    output rnd_ctr,
    output key_expand_op,
    output alert
  );

  modport merge (
    input in_ready,
    input out_valid,
    input state_we,
    input key_expand_en,
    input state_sel,
    input add_rk_sel,
    input rnd_ctr,
    input key_expand_op,
    input alert
  );

endinterface

// ==== source/aes_ctrl_pkg.sv ====
package aes_ctrl_pkg;

  //////////////////////////////////////////////////
  // Sparse encodings
  //////////////////////////////////////////////////

  parameter int Sp2VWidth = 2;

  // Bit 0 is the active-high rail, bit 1 the active-low rail
  typedef enum logic [Sp2VWidth-1:0] {
    SP2V_HIGH = 2'b01,
    SP2V_LOW  = 2'b10
  } sp2v_e;

  // Same word seen as a code or as its two rail bits
  typedef union packed {
    sp2v_e code;
    struct packed {
      logic rail_n;
      logic rail_p;
    } rails;
  } sp2v_u;

  //////////////////////////////////////////////////
  // Job and data path selects
  //////////////////////////////////////////////////

  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  typedef enum logic [2:0] {
    AES_128 = 3'b001,
    AES_192 = 3'b010,
    AES_256 = 3'b100
  } key_len_e;

  typedef enum logic [2:0] {
    STATE_INIT  = 3'b001,
    STATE_ROUND = 3'b010
  } state_sel_e;

  typedef enum logic [2:0] {
    ADD_RK_INIT  = 3'b001,
    ADD_RK_ROUND = 3'b010,
    ADD_RK_FINAL = 3'b100
  } add_rk_sel_e;

  parameter int RndCtrWidth = 4;

  // Nr for the given key length
  function automatic logic [RndCtrWidth-1:0] num_rounds(key_len_e key_len);
    case (key_len)
      AES_192: return 4'd12;
      AES_256: return 4'd14;
      default: return 4'd10;
    endcase
  endfunction

  function automatic logic key_len_valid(key_len_e key_len);
    return key_len inside {AES_128, AES_192, AES_256};
  endfunction

endpackage
